// File: Bender.yml
package:
  name: seq_top

sources:
  - seq_pkg.sv
  - seq_dispatch.sv
  - seq_mult.sv
  - seq_alu.sv
  - seq_lane.sv
  - seq_collect.sv
  - seq_top.sv
  - target: test
    files:
      - tb_seq_top.sv

// File: seq_alu.sv
module seq_alu (
   input  logic                          clk,
   input  logic                          i_rst,
   input  logic                          i_valid,
   input  seq_pkg::seq_op_e              i_op,
   input  logic [seq_pkg::ALU_WIDTH-1:0] i_data_a,
   input  logic [seq_pkg::ALU_WIDTH-1:0] i_data_b,
   input  logic [seq_pkg::IMM_WIDTH-1:0] i_const,
   output logic [seq_pkg::ALU_WIDTH-1:0] o_data,
   output logic                          o_ovf,
   output logic                          o_valid
);
   import seq_pkg::*;

   logic [ALU_WIDTH:0]   add_full;
   logic [ALU_WIDTH-1:0] s1_data_d;
   logic                 s1_ovf_d;
   logic [ALU_WIDTH-1:0] data_q1, data_q2;
   logic                 ovf_q1, ovf_q2;
   logic                 vld_q1, vld_q2;   // Non-multiply ops only
   logic [ALU_WIDTH-1:0] mult_data;
   logic                 mult_ovf;
   logic                 mult_valid;

   assign add_full = {1'b0, i_data_a} + {1'b0, i_data_b};

   always_comb begin
      case (i_op)
         OP_PUSH: begin
            s1_data_d = {i_data_a[ALU_WIDTH-IMM_WIDTH-1:0], i_const};   // Upper bits dropped
            s1_ovf_d  = |i_data_a[ALU_WIDTH-1 -: IMM_WIDTH];
         end
         OP_ADD: begin
            s1_data_d = add_full[ALU_WIDTH-1:0];
            s1_ovf_d  = add_full[ALU_WIDTH];   // Carry out
         end
         default: begin
            s1_data_d = i_data_a;
            s1_ovf_d  = 1'b0;
         end
      endcase
   end

   // Extra stage lines short ops up with the multiplier
   always_ff @(posedge clk) begin
      data_q1 <= s1_data_d;
      ovf_q1  <= s1_ovf_d;
      data_q2 <= data_q1;
      ovf_q2  <= ovf_q1;
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         vld_q1 <= 1'b0;
         vld_q2 <= 1'b0;
      end else begin
         vld_q1 <= i_valid && (i_op != OP_MULT);
         vld_q2 <= vld_q1;
      end
   end

   seq_mult u_mult (
      .clk      (clk),
      .i_rst    (i_rst),
      .i_valid  (i_valid && (i_op == OP_MULT)),
      .i_data_a (i_data_a),
      .i_data_b (i_data_b),
      .o_data   (mult_data),
      .o_ovf    (mult_ovf),
      .o_valid  (mult_valid)
   );

   assign o_data  = mult_valid ? mult_data : data_q2;   // Multiply slot wins
   assign o_ovf   = mult_valid ? mult_ovf : ovf_q2;
   assign o_valid = vld_q2 | mult_valid;

   a_fixed_latency: assert property (
      @(posedge clk) disable iff (i_rst)
      i_valid |-> ##2 o_valid
   ) else $error("ALU result did not appear two cycles after launch");

endmodule

// File: seq_collect.sv
module seq_collect #(
   parameter int NUM_LANES = 4
) (
   input  logic                                   clk,
   input  logic                                   i_rst,
   input  logic                                   i_ovf_clear,
   input  logic [NUM_LANES-1:0]                   i_done,
   input  seq_pkg::seq_result_t [NUM_LANES-1:0]   i_result,
   output logic                                   o_res_valid,
   output seq_pkg::seq_result_t                   o_res,
   output logic [NUM_LANES-1:0]                   o_ovf_sticky
);
   import seq_pkg::*;

   seq_result_t          sel_result;
   logic [NUM_LANES-1:0] ovf_set;

   // At most one lane completes per cycle, so a plain mux is enough
   always_comb begin
      sel_result = '0;
      for (int i = 0; i < NUM_LANES; i++) begin
         if (i_done[i]) begin
            sel_result = i_result[i];
         end
      end
   end

   always_comb begin
      for (int i = 0; i < NUM_LANES; i++) begin
         ovf_set[i] = i_done[i] && i_result[i].ovf;
      end
   end

   always_ff @(posedge clk) begin
      o_res <= sel_result;
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_res_valid  <= 1'b0;
         o_ovf_sticky <= '0;
      end else begin
         o_res_valid <= |i_done;   // Edge N+4
         if (i_ovf_clear) begin
            o_ovf_sticky <= ovf_set;   // New overflow survives a clear
         end else begin
            o_ovf_sticky <= o_ovf_sticky | ovf_set;
         end
      end
   end

   a_single_completion: assert property (
      @(posedge clk) disable iff (i_rst)
      $onehot0(i_done)
   ) else $error("more than one lane completed in the same cycle");

endmodule

// File: seq_dispatch.sv
module seq_dispatch #(
   parameter int NUM_LANES = 4
) (
   input  logic                 clk,
   input  logic                 i_rst,
   input  logic                 i_instr_valid,
   input  seq_pkg::seq_instr_t  i_instr,
   output seq_pkg::seq_instr_t  o_instr,
   output logic [NUM_LANES-1:0] o_issue
);
   import seq_pkg::*;

   logic [NUM_LANES-1:0] issue_d;

   // Lane field decode, out-of-range lanes get no bit
   always_comb begin
      issue_d = '0;
      for (int i = 0; i < NUM_LANES; i++) begin
         issue_d[i] = i_instr_valid && (i_instr.lane == LANE_ID_WIDTH'(i));
      end
   end

   // Instruction word is shared by all lanes
   always_ff @(posedge clk) begin
      o_instr <= i_instr;
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_issue <= '0;
      end else begin
         o_issue <= issue_d;   // Edge N
      end
   end

   a_issue_onehot: assert property (
      @(posedge clk) disable iff (i_rst)
      $onehot0(o_issue)
   ) else $error("dispatch issued to more than one lane");

endmodule

// File: seq_lane.sv
module seq_lane #(
   parameter int LANE_ID = 0
) (
   input  logic                 clk,
   input  logic                 i_rst,
   input  logic                 i_issue,
   input  seq_pkg::seq_instr_t  i_instr,
   output logic                 o_done,
   output seq_pkg::seq_result_t o_result
);
   import seq_pkg::*;

   // Fields that ride beside the ALU pipeline
   typedef struct packed {
      seq_op_e                   op;
      logic [REG_ADDR_WIDTH-1:0] dst;
   } side_t;

   logic [ALU_WIDTH-1:0] regs [NUM_REGS];
   logic [ALU_WIDTH-1:0] rd_a;
   logic [ALU_WIDTH-1:0] rd_b;
   side_t                side_q1;
   side_t                side_q2;
   logic [ALU_WIDTH-1:0] alu_data;
   logic                 alu_ovf;
   logic                 alu_valid;

   // Operand read in the cycle after dispatch, no bypass
   assign rd_a = regs[i_instr.src_a];
   assign rd_b = regs[i_instr.src_b];

   seq_alu u_alu (
      .clk      (clk),
      .i_rst    (i_rst),
      .i_valid  (i_issue),
      .i_op     (i_instr.op),
      .i_data_a (rd_a),
      .i_data_b (rd_b),
      .i_const  (i_instr.imm),
      .o_data   (alu_data),
      .o_ovf    (alu_ovf),
      .o_valid  (alu_valid)
   );

   always_ff @(posedge clk) begin
      side_q1.op  <= i_instr.op;
      side_q1.dst <= i_instr.dst;
      side_q2     <= side_q1;
   end

   // Register file writeback at edge N+3
   always_ff @(posedge clk) begin
      if (i_rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (alu_valid) begin
         regs[side_q2.dst] <= alu_data;
      end
   end

   // Completion record, same edge as the write
   always_ff @(posedge clk) begin
      o_result.lane <= LANE_ID_WIDTH'(LANE_ID);
      o_result.op   <= side_q2.op;
      o_result.dst  <= side_q2.dst;
      o_result.data <= alu_data;
      o_result.ovf  <= alu_ovf;
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_done <= 1'b0;
      end else begin
         o_done <= alu_valid;
      end
   end

endmodule

// File: seq_mult.sv
module seq_mult (
   input  logic                          clk,
   input  logic                          i_rst,
   input  logic                          i_valid,
   input  logic [seq_pkg::ALU_WIDTH-1:0] i_data_a,
   input  logic [seq_pkg::ALU_WIDTH-1:0] i_data_b,
   output logic [seq_pkg::ALU_WIDTH-1:0] o_data,
   output logic                          o_ovf,
   output logic                          o_valid
);
   import seq_pkg::*;

   localparam int HALF     = ALU_WIDTH / 2;
   localparam int PP_WIDTH = ALU_WIDTH + HALF;

   logic [PP_WIDTH-1:0]    pp_lo_q;   // a times low byte of b
   logic [PP_WIDTH-1:0]    pp_hi_q;   // a times high byte of b
   logic                   valid_q;
   logic [2*ALU_WIDTH-1:0] product;

   // Stage one
   always_ff @(posedge clk) begin
      pp_lo_q <= i_data_a * i_data_b[HALF-1:0];
      pp_hi_q <= i_data_a * i_data_b[ALU_WIDTH-1:HALF];
   end

   assign product = {{HALF{1'b0}}, pp_lo_q} + {pp_hi_q, {HALF{1'b0}}};

   // Stage two, truncate and flag lost high half
   always_ff @(posedge clk) begin
      o_data <= product[ALU_WIDTH-1:0];
      o_ovf  <= |product[2*ALU_WIDTH-1:ALU_WIDTH];
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         valid_q <= 1'b0;
         o_valid <= 1'b0;
      end else begin
         valid_q <= i_valid;
         o_valid <= valid_q;
      end
   end

endmodule

// File: seq_pkg.sv
package seq_pkg;

   localparam int ALU_WIDTH      = 16;   // Datapath width
   localparam int IMM_WIDTH      = 4;    // Immediate field of push
   localparam int REG_ADDR_WIDTH = 2;    // Four registers per lane
   localparam int LANE_ID_WIDTH  = 2;    // Up to four lanes
   localparam int NUM_REGS       = 1 << REG_ADDR_WIDTH;

   typedef enum logic [1:0] {
      OP_PASS = 2'd0,   // Result is operand a
      OP_PUSH = 2'd1,   // Shift a left, append immediate
      OP_ADD  = 2'd2,
      OP_MULT = 2'd3    // Pipelined multiplier path
   } seq_op_e;

   // Instruction word as it arrives at the dispatcher
   typedef struct packed {
      logic [LANE_ID_WIDTH-1:0]  lane;
      seq_op_e                   op;
      logic [REG_ADDR_WIDTH-1:0] dst;
      logic [REG_ADDR_WIDTH-1:0] src_a;
      logic [REG_ADDR_WIDTH-1:0] src_b;
      logic [IMM_WIDTH-1:0]      imm;
   } seq_instr_t;

   // Completion record leaving a lane and the collector
   typedef struct packed {
      logic [LANE_ID_WIDTH-1:0]  lane;
      seq_op_e                   op;     // Echo for overflow attribution
      logic [REG_ADDR_WIDTH-1:0] dst;
      logic [ALU_WIDTH-1:0]      data;
      logic                      ovf;
   } seq_result_t;

endpackage

// File: seq_top.sv
module seq_top #(
   parameter int NUM_LANES = 4
) (
   input  logic                 clk,
   input  logic                 i_rst,
   input  logic                 i_instr_valid,
   input  seq_pkg::seq_instr_t  i_instr,
   input  logic                 i_ovf_clear,
   output logic                 o_res_valid,
   output seq_pkg::seq_result_t o_res,
   output logic [NUM_LANES-1:0] o_ovf_sticky
);
   import seq_pkg::*;

   seq_instr_t                  dsp_instr;
   logic [NUM_LANES-1:0]        dsp_issue;
   logic [NUM_LANES-1:0]        lane_done;
   seq_result_t [NUM_LANES-1:0] lane_result;

   seq_dispatch #(
      .NUM_LANES (NUM_LANES)
   ) u_dispatch (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_instr_valid (i_instr_valid),
      .i_instr       (i_instr),
      .o_instr       (dsp_instr),
      .o_issue       (dsp_issue)
   );

   for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
      seq_lane #(
         .LANE_ID (g)
      ) u_lane (
         .clk      (clk),
         .i_rst    (i_rst),
         .i_issue  (dsp_issue[g]),
         .i_instr  (dsp_instr),
         .o_done   (lane_done[g]),
         .o_result (lane_result[g])
      );
   end

   seq_collect #(
      .NUM_LANES (NUM_LANES)
   ) u_collect (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_ovf_clear  (i_ovf_clear),
      .i_done       (lane_done),
      .i_result     (lane_result),
      .o_res_valid  (o_res_valid),
      .o_res        (o_res),
      .o_ovf_sticky (o_ovf_sticky)
   );

endmodule

// File: tb_seq_top.sv
module tb_seq_top;
   timeunit 1ns;
   timeprecision 1ps;

   import seq_pkg::*;

   localparam int NUM_LANES   = 3;   // One lane id left unpopulated, its traffic is dropped
   localparam int MAX_LANES   = 1 << LANE_ID_WIDTH;
   localparam int RAND_CYCLES = 2000;
   localparam int CLK_PERIOD  = 10;
   localparam int LATENCY     = 4;   // Accept edge to o_res
   localparam int WR_DELAY    = 3;   // Accept edge to register write
   localparam int TIMEOUT_NS  = (RAND_CYCLES + 100) * CLK_PERIOD * 2;

   logic                 clk;
   logic                 i_rst;
   logic                 i_instr_valid;
   seq_instr_t           i_instr;
   logic                 i_ovf_clear;
   logic                 o_res_valid;
   seq_result_t          o_res;
   logic [NUM_LANES-1:0] o_ovf_sticky;

   integer               seed;
   int                   cyc;
   int                   err_result;
   int                   err_ovf;
   int                   err_proto;
   logic [ALU_WIDTH-1:0] model_regs [MAX_LANES][NUM_REGS];
   logic [NUM_LANES-1:0] model_sticky;
   logic                 clr_pending;   // Clear seen at the next edge
   seq_result_t          exp_q[$];
   int                   exp_due_q[$];
   seq_result_t          wr_q[$];
   int                   wr_due_q[$];

   seq_top #(
      .NUM_LANES (NUM_LANES)
   ) u_seq_top (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_instr_valid (i_instr_valid),
      .i_instr       (i_instr),
      .i_ovf_clear   (i_ovf_clear),
      .o_res_valid   (o_res_valid),
      .o_res         (o_res),
      .o_ovf_sticky  (o_ovf_sticky)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
      $display("TEST FAILED");
      $finish;
   end

   // Result of an opcode before truncation decides overflow
   function automatic logic [ALU_WIDTH:0] alu_model(input seq_op_e op,
                                                    input logic [ALU_WIDTH-1:0] a,
                                                    input logic [ALU_WIDTH-1:0] b,
                                                    input logic [IMM_WIDTH-1:0] imm);
      longint unsigned full;
      logic            ovf;
      full = a;
      case (op)
         OP_PUSH: full = (full << IMM_WIDTH) | imm;
         OP_ADD:  full = full + b;
         OP_MULT: full = full * b;
         default: full = a;
      endcase
      ovf = (full >> ALU_WIDTH) != 0;
      return {ovf, full[ALU_WIDTH-1:0]};
   endfunction

   function automatic seq_instr_t make_instr(input int lane, input seq_op_e op, input int dst,
                                             input int src_a, input int src_b, input int imm);
      seq_instr_t ins;
      ins.lane  = LANE_ID_WIDTH'(lane);
      ins.op    = op;
      ins.dst   = REG_ADDR_WIDTH'(dst);
      ins.src_a = REG_ADDR_WIDTH'(src_a);
      ins.src_b = REG_ADDR_WIDTH'(src_b);
      ins.imm   = IMM_WIDTH'(imm);
      return ins;
   endfunction

   task automatic check_result(input seq_result_t got, input seq_result_t want);
      if (got !== want) begin
         err_result++;
         $display("[FAIL] %0d ns: result mismatch, got lane %0d op %0d dst %0d data %h ovf %b",
                  $time, got.lane, got.op, got.dst, got.data, got.ovf);
         $display("       expected lane %0d op %0d dst %0d data %h ovf %b",
                  want.lane, want.op, want.dst, want.data, want.ovf);
      end
   endtask

   task automatic check_ovf(input logic [NUM_LANES-1:0] got, input logic [NUM_LANES-1:0] want);
      if (got !== want) begin
         err_ovf++;
         $display("[FAIL] %0d ns: sticky overflow flags %b, expected %b", $time, got, want);
      end
   endtask

   // Outputs after edge cyc
   task automatic check_outputs();
      seq_result_t          want;
      logic [NUM_LANES-1:0] set_vec;
      logic                 due;
      set_vec = '0;
      due     = (exp_due_q.size() > 0) && (exp_due_q[0] == cyc);
      if (due) begin
         want = exp_q.pop_front();
         void'(exp_due_q.pop_front());
         if (want.ovf) begin
            set_vec[want.lane] = 1'b1;
         end
         if (o_res_valid !== 1'b1) begin
            err_proto++;
            $display("Missing result at %0d ns: lane %0d dst %0d was due but o_res_valid was low",
                     $time, want.lane, want.dst);
         end else begin
            check_result(o_res, want);
         end
      end else if (o_res_valid !== 1'b0) begin
         err_proto++;
         $display("Unexpected result at %0d ns: o_res_valid was high with nothing due", $time);
      end
      if (clr_pending) begin
         model_sticky = set_vec;   // Set beats clear
      end else begin
         model_sticky = model_sticky | set_vec;
      end
      check_ovf(o_ovf_sticky, model_sticky);
   endtask

   // Instruction driven now is sampled at edge cyc+1
   task automatic model_accept(input logic vld, input seq_instr_t ins, input logic clr);
      int                   m;
      seq_result_t          w;
      seq_result_t          r;
      logic [ALU_WIDTH-1:0] a;
      logic [ALU_WIDTH-1:0] b;
      m           = cyc + 1;
      clr_pending = clr;
      // Writes landing at or before edge m are seen by the read after it
      while ((wr_due_q.size() > 0) && (wr_due_q[0] <= m)) begin
         w = wr_q.pop_front();
         void'(wr_due_q.pop_front());
         model_regs[w.lane][w.dst] = w.data;
      end
      if (vld && (ins.lane < NUM_LANES)) begin
         a                = model_regs[ins.lane][ins.src_a];
         b                = model_regs[ins.lane][ins.src_b];
         r.lane           = ins.lane;
         r.op             = ins.op;
         r.dst            = ins.dst;
         {r.ovf, r.data}  = alu_model(ins.op, a, b, ins.imm);
         exp_q.push_back(r);
         exp_due_q.push_back(m + LATENCY);
         wr_q.push_back(r);
         wr_due_q.push_back(m + WR_DELAY);
      end
   endtask

   task automatic run_cycle(input logic vld, input seq_instr_t ins, input logic clr);
      @(negedge clk);
      cyc++;
      check_outputs();
      i_instr_valid = vld;
      i_instr       = ins;
      i_ovf_clear   = clr;
      model_accept(vld, ins, clr);
   endtask

   // Four pushes per register fill every bit, so add and multiply overflow
   task automatic load_large_values();
      logic [31:0] r;
      for (int step = 0; step < 4; step++) begin
         for (int lane = 0; lane < MAX_LANES; lane++) begin
            for (int reg_i = 0; reg_i < NUM_REGS; reg_i++) begin
               r = $random(seed);
               run_cycle(1'b1, make_instr(lane, OP_PUSH, reg_i, reg_i, 0, {1'b1, r[2:0]}), 1'b0);
            end
         end
      end
   endtask

   task automatic directed_timing();
      run_cycle(1'b1, make_instr(1, OP_PUSH, 0, 0, 0, 5), 1'b0);
      run_cycle(1'b1, make_instr(1, OP_PASS, 1, 0, 0, 0), 1'b0);   // Old value
      run_cycle(1'b1, make_instr(1, OP_PASS, 2, 0, 0, 0), 1'b0);
      run_cycle(1'b1, make_instr(1, OP_PASS, 3, 0, 0, 0), 1'b0);
      run_cycle(1'b1, make_instr(2, OP_MULT, 0, 1, 2, 0), 1'b0);   // Back to back
      run_cycle(1'b1, make_instr(2, OP_MULT, 3, 1, 2, 0), 1'b0);
      run_cycle(1'b1, make_instr(2, OP_MULT, 1, 0, 3, 0), 1'b0);
      run_cycle(1'b1, make_instr(3, OP_ADD, 0, 1, 2, 0), 1'b1);
      repeat (LATENCY + 2) run_cycle(1'b0, '0, 1'b0);
   endtask

   task automatic random_phase();
      logic [31:0] r;
      logic        vld;
      logic        clr;
      seq_instr_t  ins;
      for (int i = 0; i < RAND_CYCLES; i++) begin
         r   = $random(seed);
         vld = (r[1:0] != 2'b00);   // About 75%
         r   = $random(seed);
         ins = r[13:0];
         r   = $random(seed);
         clr = (r % 100) < 2;
         run_cycle(vld, ins, clr);
      end
   endtask

   initial begin
      seed          = 32'he5971fa5;
      cyc           = 0;
      err_result    = 0;
      err_ovf       = 0;
      err_proto     = 0;
      model_sticky  = '0;
      clr_pending   = 1'b0;
      i_rst         = 1'b1;
      i_instr_valid = 1'b0;
      i_instr       = '0;
      i_ovf_clear   = 1'b0;
      for (int l = 0; l < MAX_LANES; l++) begin
         for (int k = 0; k < NUM_REGS; k++) begin
            model_regs[l][k] = '0;
         end
      end
      repeat (10) @(posedge clk);
      @(negedge clk);
      i_rst = 1'b0;

      load_large_values();
      directed_timing();
      random_phase();
      repeat (LATENCY + 4) run_cycle(1'b0, '0, 1'b0);   // Drain

      if (exp_q.size() != 0) begin
         err_proto++;
         $display("%0d expected results never appeared", exp_q.size());
      end
      $display("Errors: result %0d, overflow %0d, protocol %0d", err_result, err_ovf, err_proto);
      if ((err_result + err_ovf + err_proto) == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: verilog.f
seq_pkg.sv
seq_dispatch.sv
seq_mult.sv
seq_alu.sv
seq_lane.sv
seq_collect.sv
seq_top.sv
tb_seq_top.sv
